// ==== source/decode_pkg.sv ====
package decode_pkg;

    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int MEM_MASK_W = 8;

    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;
    typedef logic [FUNCT7_W-1:0]   funct7_t;
    typedef logic [MEM_MASK_W-1:0] mem_mask_t;

    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;
    localparam opcode_t OPC_JAL       = 7'b1101111;
    localparam opcode_t OPC_JALR      = 7'b1100111;
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_SYSTEM    = 7'b1110011;

    localparam inst_t   INST_EBREAK = 32'h0010_0073;
    localparam funct7_t F7_BASE     = 7'b0000000;
    localparam funct7_t F7_ALT      = 7'b0100000;   // sub, sra

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_EQ, ALU_NE,
        ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG, SRC_IMM, SRC_IMM_PC, SRC_FOUR_PC
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_type_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DOUBLE
    } mem_size_e;

    typedef struct packed {
        logic      reg_wen;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_type_e imm_type;
        alu_op_e   alu_op;
        alu_src_e  alu_src;
        logic      word_op;
        logic      branch;
        logic      jump;
        logic      jalr;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      mem_unsigned;
        mem_mask_t mem_mask;
        logic      ebreak;
        logic      illegal;
    } dec_ctrl_t;

    function automatic opcode_t inst_opcode(inst_t inst);
        return inst[6:0];
    endfunction

    function automatic funct3_t inst_funct3(inst_t inst);
        return inst[14:12];
    endfunction

    function automatic funct7_t inst_funct7(inst_t inst);
        return inst[31:25];
    endfunction

    function automatic reg_addr_t inst_rd(inst_t inst);
        return inst[11:7];
    endfunction

    function automatic reg_addr_t inst_rs1(inst_t inst);
        return inst[19:15];
    endfunction

    function automatic reg_addr_t inst_rs2(inst_t inst);
        return inst[24:20];
    endfunction

    // bytes written by a store of the given size
    function automatic mem_mask_t store_mask(mem_size_e size);
        case (size)
            MEM_BYTE: return 8'h01;
            MEM_HALF: return 8'h03;
            MEM_WORD: return 8'h0f;
            default:  return 8'hff;
        endcase
    endfunction

endpackage

// ==== source/alu_decode.sv ====
`timescale 1ns/1ps

module alu_decode (
    input  decode_pkg::inst_t     inst,
    output decode_pkg::dec_ctrl_t ctrl,
    output logic                  hit
);
    import decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    shift;     // sll or srl/sra slot
    logic    alt_ok;    // funct7 legal for register and shift forms
    logic    reg_form;
    logic    word;

    assign opcode = inst_opcode(inst);
    assign funct3 = inst_funct3(inst);
    assign funct7 = inst_funct7(inst);
    assign shift  = funct3 == 3'b001 || funct3 == 3'b101;
    assign alt_ok = funct7 == F7_BASE ||
                    (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));

    function automatic alu_op_e f3_alu_op(funct3_t f3, logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        hit      = 1'b0;
        reg_form = 1'b0;
        word     = 1'b0;
        case (opcode)
            OPC_OP: begin
                reg_form = 1'b1;
                hit      = alt_ok;
            end
            OPC_OP_IMM: begin
                // rv64 shamt is six bits, so only inst[31:26] is funct
                hit = !shift || inst[31:26] == 6'b000000 ||
                      (funct3 == 3'b101 && inst[31:26] == 6'b010000);
            end
            OPC_OP_32: begin
                reg_form = 1'b1;
                word     = 1'b1;
                hit      = (funct3 == 3'b000 || shift) && alt_ok;
            end
            OPC_OP_IMM_32: begin
                word = 1'b1;
                hit  = funct3 == 3'b000 || (shift && alt_ok);
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl = '0;
        if (hit) begin
            ctrl.reg_wen = 1'b1;
            ctrl.rd      = inst_rd(inst);
            ctrl.rs1     = inst_rs1(inst);
            ctrl.rs2     = reg_form ? inst_rs2(inst) : '0;
            if (reg_form) begin
                ctrl.imm_type = IMM_NONE;
            end else if (shift) begin
                ctrl.imm_type = IMM_SHAMT;
            end else begin
                ctrl.imm_type = IMM_I;
            end
            // inst[30] is an immediate bit for addi and friends
            ctrl.alu_op  = f3_alu_op(funct3, inst[30] && (reg_form || shift));
            ctrl.alu_src = reg_form ? SRC_REG : SRC_IMM;
            ctrl.word_op = word;
        end
    end

    assert property (@(inst) hit && !reg_form |-> ctrl.alu_op != ALU_SUB);   // no subi
    assert property (@(inst) hit && word |->
                     ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA});

endmodule

// ==== source/mem_decode.sv ====
`timescale 1ns/1ps

module mem_decode (
    input  decode_pkg::inst_t     inst,
    output decode_pkg::dec_ctrl_t ctrl,
    output logic                  hit
);
    import decode_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    mem_size_e size;
    logic      load;
    logic      store;

    assign opcode = inst_opcode(inst);
    assign funct3 = inst_funct3(inst);
    assign size   = mem_size_e'(funct3[1:0]);

    assign load  = opcode == OPC_LOAD && funct3 != 3'b111;   // no ldu
    assign store = opcode == OPC_STORE && !funct3[2];
    assign hit   = load || store;

    always_comb begin
        ctrl = '0;
        if (hit) begin
            ctrl.rs1      = inst_rs1(inst);
            ctrl.alu_op   = ALU_ADD;   // rs1 + offset
            ctrl.alu_src  = SRC_IMM;
            ctrl.mem_size = size;
        end
        if (load) begin
            ctrl.reg_wen      = 1'b1;
            ctrl.rd           = inst_rd(inst);
            ctrl.imm_type     = IMM_I;
            ctrl.mem_read     = 1'b1;
            ctrl.mem_unsigned = funct3[2];
        end
        if (store) begin
            ctrl.rs2       = inst_rs2(inst);
            ctrl.imm_type  = IMM_S;
            ctrl.mem_write = 1'b1;
            ctrl.mem_mask  = store_mask(size);
        end
    end

    assert property (@(inst) ctrl.mem_read |->
                     !(ctrl.mem_unsigned && ctrl.mem_size == MEM_DOUBLE));

endmodule

// ==== source/flow_decode.sv ====
`timescale 1ns/1ps

module flow_decode (
    input  decode_pkg::inst_t     inst,
    output decode_pkg::dec_ctrl_t ctrl,
    output logic                  hit
);
    import decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;

    assign opcode = inst_opcode(inst);
    assign funct3 = inst_funct3(inst);

    function automatic alu_op_e cmp_op(funct3_t f3);
        case (f3)
            3'b000:  return ALU_EQ;
            3'b001:  return ALU_NE;
            3'b100:  return ALU_LT;
            3'b101:  return ALU_GE;
            3'b110:  return ALU_LTU;
            default: return ALU_GEU;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        hit  = 1'b0;
        case (opcode)
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin   // 010 and 011 reserved
                    hit           = 1'b1;
                    ctrl.branch   = 1'b1;
                    ctrl.rs1      = inst_rs1(inst);
                    ctrl.rs2      = inst_rs2(inst);
                    ctrl.imm_type = IMM_B;
                    ctrl.alu_op   = cmp_op(funct3);
                    ctrl.alu_src  = SRC_REG;
                end
            end
            OPC_JAL, OPC_JALR: begin
                if (opcode == OPC_JAL || funct3 == 3'b000) begin
                    hit           = 1'b1;
                    ctrl.jump     = 1'b1;
                    ctrl.reg_wen  = 1'b1;
                    ctrl.rd       = inst_rd(inst);
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.alu_src  = SRC_FOUR_PC;   // link value
                    ctrl.imm_type = IMM_J;
                    if (opcode == OPC_JALR) begin
                        ctrl.jalr     = 1'b1;
                        ctrl.rs1      = inst_rs1(inst);
                        ctrl.imm_type = IMM_I;
                    end
                end
            end
            OPC_LUI, OPC_AUIPC: begin
                hit           = 1'b1;
                ctrl.reg_wen  = 1'b1;
                ctrl.rd       = inst_rd(inst);
                ctrl.imm_type = IMM_U;
                ctrl.alu_op   = ALU_ADD;
                ctrl.alu_src  = opcode == OPC_AUIPC ? SRC_IMM_PC : SRC_IMM;
            end
            OPC_SYSTEM: begin
                if (inst == INST_EBREAK) begin
                    hit         = 1'b1;
                    ctrl.ebreak = 1'b1;
                end
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
    input  decode_pkg::inst_t     inst,
    output decode_pkg::dec_ctrl_t dec
);
    import decode_pkg::*;

    dec_ctrl_t alu_ctrl;
    dec_ctrl_t mem_ctrl;
    dec_ctrl_t flow_ctrl;
    logic      alu_hit;
    logic      mem_hit;
    logic      flow_hit;

    alu_decode i_alu_decode (
        .inst (inst),
        .ctrl (alu_ctrl),
        .hit  (alu_hit)
    );

    mem_decode i_mem_decode (
        .inst (inst),
        .ctrl (mem_ctrl),
        .hit  (mem_hit)
    );

    flow_decode i_flow_decode (
        .inst (inst),
        .ctrl (flow_ctrl),
        .hit  (flow_hit)
    );

    always_comb begin
        dec = '0;
        if (alu_hit) begin
            dec = alu_ctrl;
        end else if (mem_hit) begin
            dec = mem_ctrl;
        end else if (flow_hit) begin
            dec = flow_ctrl;
        end else begin
            dec.illegal = 1'b1;   // nobody claimed it
        end
    end

    // opcode classes are disjoint across the sub-decoders
    assert property (@(inst) $onehot0({alu_hit, mem_hit, flow_hit}));

endmodule

// ==== source/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  decode_pkg::inst_t     inst,
    input  logic                  inst_valid,
    output decode_pkg::dec_ctrl_t dec,
    output logic                  dec_valid
);
    import decode_pkg::*;

    dec_ctrl_t dec_comb;

    inst_decode i_inst_decode (
        .inst (inst),
        .dec  (dec_comb)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= inst_valid;
            if (inst_valid) begin
                dec <= dec_comb;   // hold on gaps
            end
        end
    end

    assert property (@(posedge clk) $rose(arst_n) |-> !dec_valid && dec == '0);

endmodule

// ==== sim/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// one enable bit per byte of the access
function automatic mem_mask_t byte_mask(mem_size_e size);
    int nbytes;
    nbytes = 1 << int'(size);
    return mem_mask_t'((1 << nbytes) - 1);
endfunction

// expected control bundle of one instruction word, straight from the rv64i encodings
function automatic dec_ctrl_t expected_ctrl(inst_t w);
    alu_op_e   arith [8];
    alu_op_e   cmp [8];
    dec_ctrl_t c;
    opcode_t   opc;
    funct3_t   f3;
    funct7_t   top;
    logic      shift;
    logic      word;
    logic      legal;
    arith = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    cmp   = '{ALU_EQ, ALU_NE, ALU_ADD, ALU_ADD, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
    opc   = w[6:0];
    f3    = w[14:12];
    shift = f3 == 3'd1 || f3 == 3'd5;
    word  = opc == OPC_OP_32 || opc == OPC_OP_IMM_32;
    legal = 1'b1;
    c     = '0;
    case (opc)
        OPC_OP, OPC_OP_32: begin
            top   = w[31:25];
            legal = (!word || f3 == 3'd0 || shift) &&
                    (top == 7'h00 || (top == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            c.reg_wen  = 1'b1;
            c.rd       = w[11:7];
            c.rs1      = w[19:15];
            c.rs2      = w[24:20];
            c.imm_type = IMM_NONE;
            c.alu_src  = SRC_REG;
            c.alu_op   = top[5] ? (f3 == 3'd0 ? ALU_SUB : ALU_SRA) : arith[f3];
            c.word_op  = word;
        end
        OPC_OP_IMM, OPC_OP_IMM_32: begin
            // 64-bit shifts have a six bit shamt, bit 25 is part of it
            top   = word ? w[31:25] : {w[31:26], 1'b0};
            legal = word ? (f3 == 3'd0 || shift) : 1'b1;
            if (shift) begin
                legal = legal && (top == 7'h00 || (f3 == 3'd5 && top == 7'h20));
            end
            c.reg_wen  = 1'b1;
            c.rd       = w[11:7];
            c.rs1      = w[19:15];
            c.imm_type = shift ? IMM_SHAMT : IMM_I;
            c.alu_src  = SRC_IMM;
            c.alu_op   = (shift && top[5]) ? ALU_SRA : arith[f3];
            c.word_op  = word;
        end
        OPC_LOAD: begin
            legal          = f3 != 3'd7;   // no ldu
            c.reg_wen      = 1'b1;
            c.rd           = w[11:7];
            c.rs1          = w[19:15];
            c.imm_type     = IMM_I;
            c.alu_op       = ALU_ADD;
            c.alu_src      = SRC_IMM;
            c.mem_read     = 1'b1;
            c.mem_size     = mem_size_e'(f3[1:0]);
            c.mem_unsigned = f3[2];
        end
        OPC_STORE: begin
            legal       = !f3[2];
            c.rs1       = w[19:15];
            c.rs2       = w[24:20];
            c.imm_type  = IMM_S;
            c.alu_op    = ALU_ADD;
            c.alu_src   = SRC_IMM;
            c.mem_write = 1'b1;
            c.mem_size  = mem_size_e'(f3[1:0]);
            c.mem_mask  = byte_mask(c.mem_size);
        end
        OPC_BRANCH: begin
            legal      = f3 != 3'd2 && f3 != 3'd3;
            c.branch   = 1'b1;
            c.rs1      = w[19:15];
            c.rs2      = w[24:20];
            c.imm_type = IMM_B;
            c.alu_op   = cmp[f3];
            c.alu_src  = SRC_REG;
        end
        OPC_JAL, OPC_JALR: begin
            legal      = opc == OPC_JAL || f3 == 3'd0;
            c.jump     = 1'b1;
            c.jalr     = opc == OPC_JALR;
            c.reg_wen  = 1'b1;
            c.rd       = w[11:7];
            c.rs1      = c.jalr ? w[19:15] : 5'd0;
            c.imm_type = c.jalr ? IMM_I : IMM_J;
            c.alu_op   = ALU_ADD;
            c.alu_src  = SRC_FOUR_PC;   // rd gets pc + 4
        end
        OPC_LUI, OPC_AUIPC: begin
            c.reg_wen  = 1'b1;
            c.rd       = w[11:7];
            c.imm_type = IMM_U;
            c.alu_op   = ALU_ADD;
            c.alu_src  = opc == OPC_AUIPC ? SRC_IMM_PC : SRC_IMM;
        end
        OPC_SYSTEM: begin
            legal    = w == INST_EBREAK;
            c.ebreak = 1'b1;
        end
        default: begin
            legal = 1'b0;
        end
    endcase
    if (!legal) begin
        c         = '0;
        c.illegal = 1'b1;
    end
    return c;
endfunction

`endif

// ==== sim/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;
    import decode_pkg::*;

    `include "decode_model.svh"

    localparam inst_t FREE_R  = 32'h01ff_8f80;   // rd rs1 rs2
    localparam inst_t FREE_I  = 32'hffff_8f80;   // same shape for s and b
    localparam inst_t FREE_SH = 32'h03ff_8f80;
    localparam inst_t FREE_U  = 32'hffff_ff80;
    localparam int    N_FORMS = 19;
    localparam int    N_INSTS = 3000;

    typedef struct packed {
        inst_t      base;
        inst_t      free;     // bits filled at random
        logic [7:0] f3_set;   // allowed funct3 values
    } form_t;

    localparam form_t FORMS [N_FORMS] = '{
        '{32'h0000_0033, FREE_R,  8'hff},
        '{32'h4000_0033, FREE_R,  8'h21},   // sub, sra
        '{32'h0000_0013, FREE_I,  8'hdd},
        '{32'h0000_0013, FREE_SH, 8'h22},   // slli, srli
        '{32'h4000_0013, FREE_SH, 8'h20},
        '{32'h0000_003b, FREE_R,  8'h23},
        '{32'h4000_003b, FREE_R,  8'h21},
        '{32'h0000_001b, FREE_I,  8'h01},
        '{32'h0000_001b, FREE_R,  8'h22},   // slliw, srliw
        '{32'h4000_001b, FREE_R,  8'h20},
        '{32'h0000_0003, FREE_I,  8'h7f},
        '{32'h0000_0023, FREE_I,  8'h0f},
        '{32'h0000_0063, FREE_I,  8'hf3},
        '{32'h0000_0063, FREE_I,  8'h0c},   // reserved compares
        '{32'h0000_006f, FREE_U,  8'hff},
        '{32'h0000_0067, FREE_I,  8'h01},
        '{32'h0000_0037, FREE_U,  8'hff},
        '{32'h0000_0017, FREE_U,  8'hff},
        '{32'h0010_0073, 32'h0,   8'h01}
    };

    logic        clk;
    logic        arst_n;
    inst_t       inst;
    logic        inst_valid;
    dec_ctrl_t   dec;
    logic        dec_valid;
    dec_ctrl_t   exp_dec;
    logic        exp_valid;

    id_stage i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .dec        (dec),
        .dec_valid  (dec_valid)
    );

    always #4 clk = ~clk;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_valid <= 1'b0;
            exp_dec   <= '0;
        end else begin
            exp_valid <= inst_valid;
            if (inst_valid) begin
                exp_dec <= expected_ctrl(inst);
            end
        end
    end

    task automatic stop_run(string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic logic only_illegal(dec_ctrl_t d);
        dec_ctrl_t rest;
        rest         = d;
        rest.illegal = 1'b0;
        return rest == '0;
    endfunction

    function automatic inst_t random_legal();
        form_t       form;
        inst_t       w;
        int unsigned f3;
        form = FORMS[$urandom_range(0, N_FORMS - 1)];
        f3   = $urandom_range(0, 7);
        while (!form.f3_set[f3]) begin
            f3 = (f3 + 1) & 7;
        end
        w        = form.base | (inst_t'($urandom) & form.free);
        w[14:12] = f3[2:0];
        return w;
    endfunction

    task automatic wait_for_output(int max_cycles);
        int n;
        n = 0;
        while (!dec_valid && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!dec_valid) begin
            $display("timeout: dec_valid did not rise within %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    assert property (@(posedge clk) !arst_n |-> !dec_valid && dec == '0)
        else stop_run($sformatf("error at %0t: outputs not clear in reset", $time));
    assert property (@(posedge clk) dec_valid == exp_valid)
        else stop_run($sformatf("error at %0t: dec_valid %b, expected %b",
                                $time, dec_valid, exp_valid));
    assert property (@(posedge clk) dec == exp_dec)
        else stop_run($sformatf("error at %0t: dec %h, expected %h", $time, dec, exp_dec));
    assert property (@(posedge clk)
                     dec.mem_mask == (dec.mem_write ? byte_mask(dec.mem_size) : 8'h00))
        else stop_run($sformatf("error at %0t: mem_mask %h", $time, dec.mem_mask));
    assert property (@(posedge clk) dec.mem_write |-> !dec.reg_wen && dec.rd == 5'd0)
        else stop_run($sformatf("error at %0t: store writes rd %0d", $time, dec.rd));
    assert property (@(posedge clk) dec.illegal |-> only_illegal(dec))
        else stop_run($sformatf("error at %0t: illegal bundle %h", $time, dec));

    initial begin
        void'($urandom(1));
        clk        = 1'b0;
        arst_n     = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        repeat (3) begin
            @(negedge clk);
            inst       = $urandom;
            inst_valid = 1'b1;   // ignored while in reset
        end
        arst_n     = 1'b1;
        inst_valid = 1'b0;
        @(negedge clk);
        inst       = random_legal();
        inst_valid = 1'b1;
        @(negedge clk);
        inst_valid = 1'b0;
        wait_for_output(4);
        for (int i = 0; i < N_INSTS; i++) begin
            @(negedge clk);
            inst_valid = $urandom_range(0, 3) != 0;
            if ($urandom_range(0, 4) == 0) begin
                inst = $urandom;   // mostly illegal
            end else begin
                inst = random_legal();
            end
        end
        @(negedge clk);
        inst_valid = 1'b0;
        repeat (2) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+sim
source/decode_pkg.sv
source/alu_decode.sv
source/mem_decode.sv
source/flow_decode.sv
source/inst_decode.sv
source/id_stage.sv
sim/tb_id_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_id_stage -f all.f -o tb_id_stage

# a fatal check makes the binary exit non-zero
output="$(./obj_dir/tb_id_stage)" || { echo "$output"; exit 1; }
echo "$output"

grep -q "^NO ERRORS$" <<< "$output"
echo "simulation passed"
